// ==== rvCorePkg.sv ====
/*
 * Shared word types, memory depths and encodings for the RV32I subset core.
 * Blocks pull these in with a wildcard import in their module header.
 */
package rvCorePkg;

    // Data words and instruction words share one 32-bit type
    typedef logic [31:0] wordT;
    typedef logic [4:0]  regIdxT;

    // Access size follows the low two bits of the load and store funct3
    typedef logic [1:0]  memSizeT;

    // Source of the value written back into the register file
    typedef logic [1:0]  wbSelT;

    // Coarse ALU class chosen by the decoder from the opcode
    typedef logic [1:0]  aluOpT;

    // Final operation once funct3 and funct7 bit 5 are applied
    typedef logic [2:0]  aluFuncT;

    localparam int IMEM_WORDS  = 64;
    localparam int DMEM_WORDS  = 256;
    localparam int IMEM_ADDR_W = $clog2(IMEM_WORDS);
    localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);

    // Standard RV32I major opcodes for the supported subset
    localparam logic [6:0] OPC_RTYPE  = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_ITYPE  = 7'b0010011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // Size codes line up with funct3[1:0] of lb/lh/lw and sb/sh/sw
    localparam memSizeT MEM_BYTE = 2'd0;
    localparam memSizeT MEM_HALF = 2'd1;
    localparam memSizeT MEM_WORD = 2'd2;

    localparam wbSelT WB_ALU  = 2'd0;
    localparam wbSelT WB_LOAD = 2'd1;
    localparam wbSelT WB_IMM  = 2'd2;
    localparam wbSelT WB_PC4  = 2'd3;

    // Bit 1 marks a funct3-driven class and bit 0 marks branch or immediate
    localparam aluOpT ALUOP_ADD   = 2'b00;
    localparam aluOpT ALUOP_SUB   = 2'b01;
    localparam aluOpT ALUOP_RFUNC = 2'b10;
    localparam aluOpT ALUOP_IFUNC = 2'b11;

    localparam aluFuncT ALU_ADD = 3'd0;
    localparam aluFuncT ALU_SUB = 3'd1;
    localparam aluFuncT ALU_AND = 3'd2;
    localparam aluFuncT ALU_OR  = 3'd3;
    localparam aluFuncT ALU_XOR = 3'd4;
    localparam aluFuncT ALU_SLT = 3'd5;

endpackage

// ==== source/ctrlIf.sv ====
/*
 * Decoded control bundle shared by the decoder and the datapath blocks.
 * The decoder drives it and each consumer sees only its own fields.
 */
`timescale 1ns/100ps

interface ctrlIf import rvCorePkg::*; ();

    // Program flow
    logic    branch;
    logic    branchNe;
    logic    jump;

    // Write-back
    wbSelT   wbSel;
    logic    regWrite;

    // ALU operation and operand select
    aluOpT   aluOp;
    logic    aluSrc;
    logic [2:0] funct3;
    logic    funct7b5;

    // Data memory access
    logic    memWrite;
    logic    memRead;
    memSizeT memSize;
    logic    loadUnsigned;

    modport dec (
        output branch, branchNe, jump, wbSel, regWrite,
        output aluOp, aluSrc, funct3, funct7b5,
        output memWrite, memRead, memSize, loadUnsigned
    );

    modport fetch (input branch, branchNe, jump);
    modport alu (input aluOp, aluSrc, funct3, funct7b5);
    modport mem (input memWrite, memRead, memSize, loadUnsigned);
    modport wb (input regWrite, wbSel);

endinterface

// ==== source/instrDecoder.sv ====
/*
 * Combinational instruction decoder for the RV32I subset.
 * Drives the control bundle, the register indices and the sign-extended immediate.
 */
`timescale 1ns/100ps

module instrDecoder import rvCorePkg::*; (
    input  wordT   instr,
    ctrlIf.dec     ctrl,
    output regIdxT rs1,
    output regIdxT rs2,
    output regIdxT rd,
    output wordT   imm,
    output logic   illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       isRType;
    logic       isLoad;
    logic       isIType;
    logic       isStore;
    logic       isBranch;
    logic       isLui;
    logic       isJal;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // Register fields sit at fixed positions in every format
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    assign isRType  = (opcode == OPC_RTYPE);
    assign isLoad   = (opcode == OPC_LOAD);
    assign isIType  = (opcode == OPC_ITYPE);
    assign isStore  = (opcode == OPC_STORE);
    assign isBranch = (opcode == OPC_BRANCH);
    assign isLui    = (opcode == OPC_LUI);
    assign isJal    = (opcode == OPC_JAL);

    // Anything else retires as a no-op since every enable below stays low
    assign illegal = ~(isRType | isLoad | isIType | isStore | isBranch | isLui | isJal);

    // Only beq (000) and bne (001) redirect the pc
    assign ctrl.branch   = isBranch & (funct3[2:1] == 2'b00);
    assign ctrl.branchNe = isBranch & funct3[0];
    assign ctrl.jump     = isJal;

    assign ctrl.wbSel = isLoad ? WB_LOAD :
                        isLui  ? WB_IMM  :
                        isJal  ? WB_PC4  :
                                 WB_ALU;

    // Stores and branches write no register while jal writes its link address
    assign ctrl.regWrite = isRType | isLoad | isIType | isLui | isJal;

    // Branches subtract to compare while loads and stores add for the address
    assign ctrl.aluOp = isRType  ? ALUOP_RFUNC :
                        isIType  ? ALUOP_IFUNC :
                        isBranch ? ALUOP_SUB   :
                                   ALUOP_ADD;
    assign ctrl.aluSrc   = isLoad | isIType | isStore;
    assign ctrl.funct3   = funct3;
    assign ctrl.funct7b5 = instr[30];

    // The eight load/store selects collapse into a size and an unsigned flag
    assign ctrl.memWrite     = isStore;
    assign ctrl.memRead      = isLoad;
    assign ctrl.memSize      = funct3[1:0];
    assign ctrl.loadUnsigned = funct3[2];

    // Immediate layout depends on the instruction format
    always_comb begin
        case (opcode)
            OPC_LOAD, OPC_ITYPE: imm = {{20{instr[31]}}, instr[31:20]};
            OPC_STORE:           imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            OPC_BRANCH: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            OPC_LUI:             imm = {instr[31:12], 12'h000};
            OPC_JAL: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default:             imm = '0;
        endcase
    end

    // Loads and stores only come in byte, half and word sizes
    always_comb begin
        assert (!(ctrl.memRead || ctrl.memWrite) ||
                (ctrl.memSize inside {MEM_BYTE, MEM_HALF, MEM_WORD}))
            else $error("unsupported access size %0d on a load or store", ctrl.memSize);
    end

endmodule

// ==== source/fetchUnit.sv ====
/*
 * Program counter, instruction memory and next-pc selection.
 * The memory is filled through the load strobe while the core is halted.
 */
`timescale 1ns/100ps

module fetchUnit import rvCorePkg::*; (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   run,
    input  logic                   imemWe,
    input  logic [IMEM_ADDR_W-1:0] imemAddr,
    input  wordT                   imemData,
    ctrlIf.fetch                   ctrl,
    input  logic                   zero,
    input  wordT                   imm,
    output wordT                   pc,
    output wordT                   pcPlus4,
    output wordT                   instr
);

    wordT imem [IMEM_WORDS];
    wordT nextPc;
    logic taken;

    // Loading is only allowed while the core is halted
    always_ff @(posedge clk) begin
        if (imemWe && !run) begin
            imem[imemAddr] <= imemData;
        end
    end

    // The word index drops the two low pc bits
    assign instr   = imem[pc[IMEM_ADDR_W+1:2]];
    assign pcPlus4 = pc + 32'd4;

    // beq takes the branch on zero and bne on non-zero
    assign taken  = ctrl.jump | (ctrl.branch & (zero ^ ctrl.branchNe));
    assign nextPc = taken ? (pc + imm) : pcPlus4;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (run) begin
            pc <= nextPc;
        end
    end

    // A B or J offset with bit 1 set would move the pc off a word boundary
    assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

endmodule

// ==== source/aluUnit.sv ====
/*
 * ALU operation decode and the 32-bit arithmetic and logic unit.
 * Operand B comes from rs2 or the immediate, and zero feeds the branch logic.
 */
`timescale 1ns/100ps

module aluUnit import rvCorePkg::*; (
    ctrlIf.alu   ctrl,
    input  wordT rs1Data,
    input  wordT rs2Data,
    input  wordT imm,
    output wordT aluResult,
    output logic zero
);

    aluFuncT func;
    wordT    opB;

    // Loads, stores and immediate ops all take the immediate as operand B
    assign opB = ctrl.aluSrc ? imm : rs2Data;

    always_comb begin
        case (ctrl.aluOp)
            ALUOP_ADD: func = ALU_ADD;
            ALUOP_SUB: func = ALU_SUB;
            default: begin
                // Register and immediate classes share the funct3 map
                case (ctrl.funct3)
                    3'b000: begin
                        // funct7 bit 5 only means sub for register ops, addi ignores it
                        if (ctrl.aluOp == ALUOP_RFUNC && ctrl.funct7b5) begin
                            func = ALU_SUB;
                        end else begin
                            func = ALU_ADD;
                        end
                    end
                    3'b010:  func = ALU_SLT;
                    3'b100:  func = ALU_XOR;
                    3'b110:  func = ALU_OR;
                    3'b111:  func = ALU_AND;
                    default: func = ALU_ADD;
                endcase
            end
        endcase
    end

    always_comb begin
        case (func)
            ALU_SUB: aluResult = rs1Data - opB;
            ALU_AND: aluResult = rs1Data & opB;
            ALU_OR:  aluResult = rs1Data | opB;
            ALU_XOR: aluResult = rs1Data ^ opB;
            // Signed compare so negative operands order correctly
            ALU_SLT: aluResult = {31'd0, $signed(rs1Data) < $signed(opB)};
            default: aluResult = rs1Data + opB;
        endcase
    end

    // Zero after a subtract means the branch operands were equal
    assign zero = (aluResult == '0);

endmodule

// ==== source/registerFile.sv ====
/*
 * Register file with 32 entries, two combinational reads and one write port.
 * Also picks the write-back source and shows each write as a retire strobe.
 */
`timescale 1ns/100ps

module registerFile import rvCorePkg::*; (
    input  logic   clk,
    input  logic   arstN,
    input  logic   run,
    ctrlIf.wb      ctrl,
    input  regIdxT rs1,
    input  regIdxT rs2,
    input  regIdxT rd,
    input  wordT   aluResult,
    input  wordT   loadData,
    input  wordT   imm,
    input  wordT   pcPlus4,
    output wordT   rs1Data,
    output wordT   rs2Data,
    output logic   wbValid,
    output regIdxT wbRd,
    output wordT   wbData
);

    wordT regs [32];
    logic wrEn;

    always_comb begin
        case (ctrl.wbSel)
            WB_LOAD: wbData = loadData;
            WB_IMM:  wbData = imm;
            WB_PC4:  wbData = pcPlus4;
            default: wbData = aluResult;
        endcase
    end

    // Writes to x0 are dropped so they never show up as a strobe
    assign wrEn    = run & ctrl.regWrite & (rd != '0);
    assign wbValid = wrEn;
    assign wbRd    = rd;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[rd] <= wbData;
        end
    end

    // x0 is hard-wired to zero on both read ports
    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== source/loadStoreUnit.sv ====
/*
 * Data memory with byte lanes, store alignment and load extension.
 * Reads are combinational and the enabled lanes are written at the clock edge.
 */
`timescale 1ns/100ps

module loadStoreUnit import rvCorePkg::*; (
    input  logic       clk,
    input  logic       run,
    ctrlIf.mem         ctrl,
    input  wordT       addr,
    input  wordT       storeSrc,
    output wordT       loadData,
    output logic       storeValid,
    output wordT       storeAddr,
    output logic [3:0] storeMask,
    output wordT       storeData
);

    wordT                   dmem [DMEM_WORDS];
    logic [DMEM_ADDR_W-1:0] wordIdx;
    logic [1:0]             byteOff;
    wordT                   rdWord;
    wordT                   byteLane;
    wordT                   halfLane;

    assign wordIdx = addr[DMEM_ADDR_W+1:2];
    assign byteOff = addr[1:0];

    // Store data is replicated so each lane already holds the right bytes
    always_comb begin
        case (ctrl.memSize)
            MEM_BYTE: begin
                storeData = {4{storeSrc[7:0]}};
                storeMask = 4'b0001 << byteOff;
            end
            MEM_HALF: begin
                storeData = {2{storeSrc[15:0]}};
                storeMask = 4'b0011 << {byteOff[1], 1'b0};
            end
            default: begin
                storeData = storeSrc;
                storeMask = 4'b1111;
            end
        endcase
    end

    assign storeValid = run & ctrl.memWrite;
    assign storeAddr  = {addr[31:2], 2'b00};

    always_ff @(posedge clk) begin
        if (storeValid) begin
            for (int i = 0; i < 4; i++) begin
                if (storeMask[i]) begin
                    dmem[wordIdx][8*i +: 8] <= storeData[8*i +: 8];
                end
            end
        end
    end

    // Shift the addressed byte or half down to bit 0 before extending
    assign rdWord   = dmem[wordIdx];
    assign byteLane = rdWord >> {byteOff, 3'b000};
    assign halfLane = rdWord >> {byteOff[1], 4'b0000};

    always_comb begin
        loadData = '0;
        if (ctrl.memRead) begin
            case (ctrl.memSize)
                MEM_BYTE: begin
                    loadData = {{24{~ctrl.loadUnsigned & byteLane[7]}}, byteLane[7:0]};
                end
                MEM_HALF: begin
                    loadData = {{16{~ctrl.loadUnsigned & halfLane[15]}}, halfLane[15:0]};
                end
                default:  loadData = rdWord;
            endcase
        end
    end

    // The address from the ALU must match the access size from the decoder
    assert property (@(posedge clk) (run && (ctrl.memRead || ctrl.memWrite)) |->
        (ctrl.memSize == MEM_BYTE) ||
        (ctrl.memSize == MEM_HALF && addr[0] == 1'b0) ||
        (addr[1:0] == 2'b00))
        else $error("misaligned access: size %0d addr %h", ctrl.memSize, addr);

endmodule

// ==== source/rvCore.sv ====
/*
 * Top level of the single-cycle RV32I subset core.
 * Wires the blocks together and exposes the load port and retire strobes.
 */
`timescale 1ns/100ps

module rvCore import rvCorePkg::*; (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   run,
    input  logic                   imemWe,
    input  logic [IMEM_ADDR_W-1:0] imemAddr,
    input  wordT                   imemData,
    output wordT                   pc,
    output logic                   wbValid,
    output regIdxT                 wbRd,
    output wordT                   wbData,
    output logic                   storeValid,
    output wordT                   storeAddr,
    output logic [3:0]             storeMask,
    output wordT                   storeData
);

    wordT   pcPlus4;
    wordT   instr;
    regIdxT rs1;
    regIdxT rs2;
    regIdxT rd;
    wordT   imm;
    logic   illegal;
    wordT   rs1Data;
    wordT   rs2Data;
    wordT   aluResult;
    logic   zero;
    wordT   loadData;

    // Decoded control shared by all datapath blocks
    ctrlIf ctrlBus ();

    fetchUnit uFetch (
        .clk      (clk),
        .arstN    (arstN),
        .run      (run),
        .imemWe   (imemWe),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .ctrl     (ctrlBus),
        .zero     (zero),
        .imm      (imm),
        .pc       (pc),
        .pcPlus4  (pcPlus4),
        .instr    (instr)
    );

    // Unsupported opcodes only raise illegal, which stays inside the core
    instrDecoder uDecoder (
        .instr   (instr),
        .ctrl    (ctrlBus),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .imm     (imm),
        .illegal (illegal)
    );

    registerFile uRegs (
        .clk       (clk),
        .arstN     (arstN),
        .run       (run),
        .ctrl      (ctrlBus),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .aluResult (aluResult),
        .loadData  (loadData),
        .imm       (imm),
        .pcPlus4   (pcPlus4),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .wbValid   (wbValid),
        .wbRd      (wbRd),
        .wbData    (wbData)
    );

    aluUnit uAlu (
        .ctrl      (ctrlBus),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .imm       (imm),
        .aluResult (aluResult),
        .zero      (zero)
    );

    // The ALU result is the byte address for loads and stores
    loadStoreUnit uLsu (
        .clk        (clk),
        .run        (run),
        .ctrl       (ctrlBus),
        .addr       (aluResult),
        .storeSrc   (rs2Data),
        .loadData   (loadData),
        .storeValid (storeValid),
        .storeAddr  (storeAddr),
        .storeMask  (storeMask),
        .storeData  (storeData)
    );

endmodule

// ==== testbench/rvCoreChecker.sv ====
/*
 * Watches the core's retire ports and compares each edge against the program table.
 * Rows are consumed in retire order while run is high, one row per rising edge.
 */
`timescale 1ns/100ps

module rvCoreChecker import rvCorePkg::*; #(
    parameter int ROWS = 1
) (
    input  logic       clk,
    input  logic       run,
    input  wordT       pc,
    input  logic       wbValid,
    input  regIdxT     wbRd,
    input  wordT       wbData,
    input  logic       storeValid,
    input  wordT       storeAddr,
    input  logic [3:0] storeMask,
    input  wordT       storeData,
    input  wordT       expPc [ROWS],
    input  logic [1:0] expKind [ROWS],
    input  regIdxT     expRd [ROWS],
    input  wordT       expVal [ROWS],
    input  wordT       expAddr [ROWS],
    input  logic [3:0] expMask [ROWS],
    input  int         rowGroup [ROWS],
    output logic       done,
    output int         rowsChecked,
    output int         errCount
);

    int idx;
    int groupErr;

    initial begin
        idx      = 0;
        errCount = 0;
        groupErr = 0;
    end

    assign done        = (idx == ROWS);
    assign rowsChecked = idx;

    function automatic string groupName(input int g);
        case (g)
            1:       return "register and immediate ALU ops";
            2:       return "lui and jal";
            3:       return "stores";
            4:       return "loads";
            5:       return "beq and bne";
            default: return "register zero";
        endcase
    endfunction

    task automatic mismatch(input string name, input wordT expected, input wordT actual);
        $display("ERR %s expected %h got %h (row %0d)", name, expected, actual, idx);
        errCount++;
        groupErr++;
    endtask

    task automatic complain(input string what);
        $display("row %0d, pc %h: %s", idx, pc, what);
        errCount++;
        groupErr++;
    endtask

    // Kind bit 0 marks a register write and bit 1 marks a store
    task automatic checkRow();
        if (pc !== expPc[idx]) begin
            mismatch("pc", expPc[idx], pc);
        end
        if (expKind[idx][0]) begin
            if (wbValid !== 1'b1) begin
                complain("the expected register write did not happen");
            end else begin
                if (wbRd !== expRd[idx]) mismatch("wbRd", 32'(expRd[idx]), 32'(wbRd));
                if (wbData !== expVal[idx]) mismatch("wbData", expVal[idx], wbData);
            end
        end else if (wbValid !== 1'b0) begin
            complain("a register write strobe appeared where none was expected");
        end
        if (expKind[idx][1]) begin
            if (storeValid !== 1'b1) begin
                complain("the expected store did not happen");
            end else begin
                if (storeAddr !== expAddr[idx]) mismatch("storeAddr", expAddr[idx], storeAddr);
                if (storeMask !== expMask[idx]) begin
                    mismatch("storeMask", 32'(expMask[idx]), 32'(storeMask));
                end
                if (storeData !== expVal[idx]) mismatch("storeData", expVal[idx], storeData);
            end
        end else if (storeValid !== 1'b0) begin
            complain("a store strobe appeared where none was expected");
        end
    endtask

    // Outputs are combinational from pc and inputs change on the falling edge
    always @(posedge clk) begin
        if (!run) begin
            if (wbValid !== 1'b0 || storeValid !== 1'b0) begin
                complain("a strobe was raised while the core was halted");
            end
        end else if (done) begin
            complain("the core retired past the end of the program table");
        end else begin
            checkRow();
            if (idx == ROWS - 1 || rowGroup[idx + 1] != rowGroup[idx]) begin
                if (groupErr == 0) begin
                    $display("group %0d, %s: all rows match", rowGroup[idx],
                             groupName(rowGroup[idx]));
                end else begin
                    $display("group %0d, %s: %0d mismatches", rowGroup[idx],
                             groupName(rowGroup[idx]), groupErr);
                end
                groupErr = 0;
            end
            idx++;
        end
    end

endmodule

// ==== testbench/rvCoreTb.sv ====
/*
 * Testbench for the single-cycle core: loads a program table through the load
 * port with run low, then runs it while the checker follows every retire.
 */
`timescale 1ns/100ps

module rvCoreTb import rvCorePkg::*; ();

    localparam int ROWS           = 37;
    localparam int TIMEOUT_CYCLES = 16 + IMEM_WORDS + 2 * ROWS + 20;

    logic                   clk;
    logic                   arstN;
    logic                   run;
    logic                   imemWe;
    logic [IMEM_ADDR_W-1:0] imemAddr;
    wordT                   imemData;
    wordT                   pc;
    logic                   wbValid;
    regIdxT                 wbRd;
    wordT                   wbData;
    logic                   storeValid;
    wordT                   storeAddr;
    logic [3:0]             storeMask;
    wordT                   storeData;
    logic                   done;
    int                     rowsChecked;
    int                     errCount;

    // Program table, one row per retiring instruction in retire order
    wordT       prog [ROWS];
    wordT       expPc [ROWS];
    logic [1:0] expKind [ROWS];
    regIdxT     expRd [ROWS];
    wordT       expVal [ROWS];
    wordT       expAddr [ROWS];
    logic [3:0] expMask [ROWS];
    int         rowGroup [ROWS];
    int         nextRow;
    int         curGroup;

    rvCore dut (
        .clk        (clk),
        .arstN      (arstN),
        .run        (run),
        .imemWe     (imemWe),
        .imemAddr   (imemAddr),
        .imemData   (imemData),
        .pc         (pc),
        .wbValid    (wbValid),
        .wbRd       (wbRd),
        .wbData     (wbData),
        .storeValid (storeValid),
        .storeAddr  (storeAddr),
        .storeMask  (storeMask),
        .storeData  (storeData)
    );

    rvCoreChecker #(.ROWS(ROWS)) uChecker (
        .clk (clk), .run (run), .pc (pc),
        .wbValid (wbValid), .wbRd (wbRd), .wbData (wbData),
        .storeValid (storeValid), .storeAddr (storeAddr),
        .storeMask (storeMask), .storeData (storeData),
        .expPc (expPc), .expKind (expKind), .expRd (expRd), .expVal (expVal),
        .expAddr (expAddr), .expMask (expMask), .rowGroup (rowGroup),
        .done (done), .rowsChecked (rowsChecked), .errCount (errCount)
    );

    // RV32I instruction encoders
    function automatic wordT rType(input logic f7b5, input regIdxT rs2, input regIdxT rs1,
                                   input logic [2:0] f3, input regIdxT rd);
        return {1'b0, f7b5, 5'b00000, rs2, rs1, f3, rd, OPC_RTYPE};
    endfunction

    function automatic wordT iType(input logic [11:0] imm, input regIdxT rs1,
                                   input logic [2:0] f3, input regIdxT rd,
                                   input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic wordT sType(input logic [11:0] imm, input regIdxT rs2,
                                   input regIdxT rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic wordT bType(input logic [12:0] imm, input regIdxT rs2,
                                   input regIdxT rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic wordT jType(input logic [20:0] imm, input regIdxT rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // Skipped slots hold addi x31 with an immediate built from the slot index
    function automatic wordT fillWord(input int idx);
        return iType({6'h3F, 6'(idx)}, 5'd0, 3'b000, 5'd31, OPC_ITYPE);
    endfunction

    task automatic addRow(input wordT instr, input wordT pcVal, input logic [1:0] kind,
                          input regIdxT rd, input wordT val, input wordT addr,
                          input logic [3:0] mask);
        prog[nextRow]     = instr;
        expPc[nextRow]    = pcVal;
        expKind[nextRow]  = kind;
        expRd[nextRow]    = rd;
        expVal[nextRow]   = val;
        expAddr[nextRow]  = addr;
        expMask[nextRow]  = mask;
        rowGroup[nextRow] = curGroup;
        nextRow++;
    endtask

    task automatic wbRow(input wordT instr, input wordT pcVal, input regIdxT rd, input wordT val);
        addRow(instr, pcVal, 2'b01, rd, val, '0, '0);
    endtask

    task automatic storeRow(input wordT instr, input wordT pcVal, input wordT addr,
                            input logic [3:0] mask, input wordT data);
        addRow(instr, pcVal, 2'b10, '0, data, addr, mask);
    endtask

    task automatic quietRow(input wordT instr, input wordT pcVal);
        addRow(instr, pcVal, 2'b00, '0, '0, '0, '0);
    endtask

    task automatic buildProgram();
        nextRow  = 0;
        curGroup = 1;
        // x1 = 5 and x2 = -3 feed the ALU rows
        wbRow(iType(12'h005, 5'd0, 3'b000, 5'd1, OPC_ITYPE), 32'd0, 5'd1, 32'h0000_0005);
        wbRow(iType(12'hFFD, 5'd0, 3'b000, 5'd2, OPC_ITYPE), 32'd4, 5'd2, 32'hFFFF_FFFD);
        wbRow(rType(1'b0, 5'd2, 5'd1, 3'b000, 5'd3), 32'd8, 5'd3, 32'h0000_0002);
        wbRow(rType(1'b1, 5'd2, 5'd1, 3'b000, 5'd4), 32'd12, 5'd4, 32'h0000_0008);
        wbRow(rType(1'b0, 5'd2, 5'd1, 3'b111, 5'd5), 32'd16, 5'd5, 32'h0000_0005);
        wbRow(rType(1'b0, 5'd2, 5'd1, 3'b110, 5'd6), 32'd20, 5'd6, 32'hFFFF_FFFD);
        wbRow(rType(1'b0, 5'd2, 5'd1, 3'b100, 5'd7), 32'd24, 5'd7, 32'hFFFF_FFF8);
        wbRow(rType(1'b0, 5'd1, 5'd2, 3'b010, 5'd8), 32'd28, 5'd8, 32'h0000_0001);
        wbRow(rType(1'b0, 5'd2, 5'd1, 3'b010, 5'd9), 32'd32, 5'd9, 32'h0000_0000);
        wbRow(iType(12'hFFF, 5'd2, 3'b010, 5'd10, OPC_ITYPE), 32'd36, 5'd10, 32'h0000_0001);
        wbRow(iType(12'h0F0, 5'd7, 3'b111, 5'd11, OPC_ITYPE), 32'd40, 5'd11, 32'h0000_00F0);
        wbRow(iType(12'h700, 5'd1, 3'b110, 5'd12, OPC_ITYPE), 32'd44, 5'd12, 32'h0000_0705);
        wbRow(iType(12'hFFF, 5'd1, 3'b100, 5'd13, OPC_ITYPE), 32'd48, 5'd13, 32'hFFFF_FFFA);
        curGroup = 2;
        wbRow({20'h12345, 5'd14, OPC_LUI}, 32'd52, 5'd14, 32'h1234_5000);
        // jal skips the slots at 60 and 64
        wbRow(jType(21'd12, 5'd15), 32'd56, 5'd15, 32'd60);
        wbRow({20'hABCDE, 5'd20, OPC_LUI}, 32'd68, 5'd20, 32'hABCD_E000);
        curGroup = 3;
        wbRow(iType(12'h100, 5'd0, 3'b000, 5'd16, OPC_ITYPE), 32'd72, 5'd16, 32'h0000_0100);
        wbRow(iType(12'h678, 5'd14, 3'b000, 5'd17, OPC_ITYPE), 32'd76, 5'd17, 32'h1234_5678);
        storeRow(sType(12'h000, 5'd17, 5'd16, 3'b010), 32'd80, 32'h100, 4'b1111, 32'h1234_5678);
        storeRow(sType(12'h006, 5'd2, 5'd16, 3'b001), 32'd84, 32'h104, 4'b1100, 32'hFFFD_FFFD);
        storeRow(sType(12'h005, 5'd1, 5'd16, 3'b000), 32'd88, 32'h104, 4'b0010, 32'h0505_0505);
        storeRow(sType(12'h004, 5'd13, 5'd16, 3'b000), 32'd92, 32'h104, 4'b0001, 32'hFAFA_FAFA);
        // Word 0x104 now holds FFFD05FA and the first load follows the last store
        curGroup = 4;
        wbRow(iType(12'h004, 5'd16, 3'b100, 5'd25, OPC_LOAD), 32'd96, 5'd25, 32'h0000_00FA);
        wbRow(iType(12'h004, 5'd16, 3'b000, 5'd24, OPC_LOAD), 32'd100, 5'd24, 32'hFFFF_FFFA);
        wbRow(iType(12'h000, 5'd16, 3'b010, 5'd21, OPC_LOAD), 32'd104, 5'd21, 32'h1234_5678);
        wbRow(iType(12'h006, 5'd16, 3'b001, 5'd22, OPC_LOAD), 32'd108, 5'd22, 32'hFFFF_FFFD);
        wbRow(iType(12'h006, 5'd16, 3'b101, 5'd23, OPC_LOAD), 32'd112, 5'd23, 32'h0000_FFFD);
        wbRow(iType(12'h001, 5'd16, 3'b000, 5'd26, OPC_LOAD), 32'd116, 5'd26, 32'h0000_0056);
        wbRow(iType(12'h004, 5'd16, 3'b001, 5'd27, OPC_LOAD), 32'd120, 5'd27, 32'h0000_05FA);
        // beq not taken, beq taken, bne not taken, bne taken
        curGroup = 5;
        quietRow(bType(13'd8, 5'd2, 5'd1, 3'b000), 32'd124);
        quietRow(bType(13'd12, 5'd17, 5'd21, 3'b000), 32'd128);
        quietRow(bType(13'd8, 5'd1, 5'd1, 3'b001), 32'd140);
        quietRow(bType(13'd8, 5'd2, 5'd1, 3'b001), 32'd144);
        curGroup = 6;
        quietRow(iType(12'h007, 5'd1, 3'b000, 5'd0, OPC_ITYPE), 32'd152);
        wbRow(rType(1'b0, 5'd1, 5'd0, 3'b000, 5'd28), 32'd156, 5'd28, 32'h0000_0005);
        storeRow(sType(12'h008, 5'd0, 5'd16, 3'b010), 32'd160, 32'h108, 4'b1111, 32'h0);
        wbRow(iType(12'h008, 5'd16, 3'b010, 5'd29, OPC_LOAD), 32'd164, 5'd29, 32'h0);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        arstN    = 1'b0;
        run      = 1'b0;
        imemWe   = 1'b0;
        imemAddr = '0;
        imemData = '0;
        buildProgram();
        repeat (16) @(negedge clk);
        arstN = 1'b1;
        // Fill every slot first so a wrong jump lands on a detectable word
        for (int i = 0; i < IMEM_WORDS; i++) begin
            @(negedge clk);
            imemWe   = 1'b1;
            imemAddr = IMEM_ADDR_W'(i);
            imemData = fillWord(i);
        end
        for (int i = 0; i < ROWS; i++) begin
            @(negedge clk);
            imemAddr = expPc[i][IMEM_ADDR_W+1:2];
            imemData = prog[i];
        end
        @(negedge clk);
        imemWe = 1'b0;
        run    = 1'b1;
        while (!done) @(negedge clk);
        run = 1'b0;
        repeat (2) @(negedge clk);
        $display("summary: %0d of %0d rows retired, %0d errors", rowsChecked, ROWS, errCount);
        if (errCount == 0 && rowsChecked == ROWS) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Load time plus run time plus margin bounds the whole simulation
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d of %0d rows retired",
                 cycles, rowsChecked, ROWS);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== rvCore.f ====
rvCorePkg.sv
source/ctrlIf.sv
source/instrDecoder.sv
source/fetchUnit.sv
source/aluUnit.sv
source/registerFile.sv
source/loadStoreUnit.sv
source/rvCore.sv
testbench/rvCoreChecker.sv
testbench/rvCoreTb.sv

// ==== build.sh ====
#!/bin/sh
# Compiles the core and its testbench with Verilator, then runs the simulation.
# Exits non-zero unless the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module rvCoreTb -Mdir obj_dir -f rvCore.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/VrvCoreTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1
